// ==== verilog/aes_params.svh ====
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// data block width in bits
`define AES_BLK_S 128

// cipher key width, AES-128 only
`define AES_KEY_S 128

// number of rounds after the initial key addition
`define AES_NR 10

// round counter has to reach AES_NR
`define AES_RND_W 4

`endif

// ==== verilog/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

	// round controller states
	typedef enum logic [0:0] {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} cipher_state_e;

	// commands from the round controller to the key expander
	typedef enum logic [1:0] {
		KOP_HOLD = 2'b00, // keep the current round key
		KOP_LOAD = 2'b01, // cipher key becomes round key 0
		KOP_NEXT = 2'b10, // step the schedule by one round
		KOP_RSVD = 2'b11
	} key_op_e;

endpackage

`default_nettype wire

// ==== verilog/aes_sbox.sv ====
`timescale 1ns/100ps
`default_nettype none

module aes_sbox (
	input  logic [7:0] in,
	output logic [7:0] out
);

	// forward substitution table, indexed by the input byte
	localparam logic [7:0] SBOX [256] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	assign out = SBOX[in];

endmodule

`default_nettype wire

// ==== verilog/aes_round.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "aes_params.svh"

module aes_round (
	input  logic [`AES_BLK_S-1:0] round_in,
	input  logic [`AES_BLK_S-1:0] round_key,
	input  logic                  final_round,
	output logic [`AES_BLK_S-1:0] round_out
);

	// byte i of the block sits at bits [127-8i -: 8], column major
	logic [7:0] sb [16]; // after SubBytes
	logic [7:0] sr [16]; // after ShiftRows
	logic [7:0] mc [16]; // after MixColumns

	function automatic logic [7:0] xtime(input logic [7:0] b);
		xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	genvar i;
	generate
		for (i = 0; i < 16; i++) begin : g_sbox
			aes_sbox u_sbox (
				.in  (round_in[`AES_BLK_S-1-8*i -: 8]),
				.out (sb[i])
			);
		end
	endgenerate

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				sr[r + 4*c] = sb[r + 4*((c + r) % 4)]; // row r rotates left by r
			end
		end
	end

	always_comb begin : mix
		logic [7:0] a0, a1, a2, a3;
		for (int c = 0; c < 4; c++) begin
			a0 = sr[4*c];
			a1 = sr[4*c + 1];
			a2 = sr[4*c + 2];
			a3 = sr[4*c + 3];
			// 3x is folded in as xtime(x) ^ x
			mc[4*c]     = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
			mc[4*c + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
			mc[4*c + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
			mc[4*c + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
		end
	end

	always_comb begin
		for (int b = 0; b < 16; b++) begin
			round_out[`AES_BLK_S-1-8*b -: 8] = (final_round ? sr[b] : mc[b]) ^
				round_key[`AES_BLK_S-1-8*b -: 8];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/aes_key_expand.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "aes_params.svh"

module aes_key_expand (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`AES_KEY_S-1:0] key,
	input  aes_pkg::key_op_e      key_op,
	output logic [`AES_KEY_S-1:0] round_key
);

	logic [`AES_KEY_S-1:0] rk_q;
	logic [`AES_KEY_S-1:0] rk_next;
	logic [7:0]            rcon_q;

	logic [31:0] w0, w1, w2, w3;
	logic [31:0] rot_w;
	logic [31:0] sub_w;
	logic [31:0] temp_w;
	logic [31:0] n0, n1, n2, n3;

	assign {w0, w1, w2, w3} = rk_q; // w0 is the leftmost word
	assign rot_w = {w3[23:0], w3[31:24]};

	genvar i;
	generate
		for (i = 0; i < 4; i++) begin : g_subword
			aes_sbox u_sbox (
				.in  (rot_w[8*i +: 8]),
				.out (sub_w[8*i +: 8])
			);
		end
	endgenerate

	assign temp_w = sub_w ^ {rcon_q, 24'h000000};

	// each new word chains on the one just produced
	assign n0 = w0 ^ temp_w;
	assign n1 = w1 ^ n0;
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;
	assign rk_next = {n0, n1, n2, n3};

	always_ff @(posedge clk) begin
		case (key_op)
			aes_pkg::KOP_LOAD: rk_q <= key;
			aes_pkg::KOP_NEXT: rk_q <= rk_next;
			default:           rk_q <= rk_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rcon_q <= 8'h01;
		end else if (key_op == aes_pkg::KOP_LOAD) begin
			rcon_q <= 8'h01;
		end else if (key_op == aes_pkg::KOP_NEXT) begin
			rcon_q <= {rcon_q[6:0], 1'b0} ^ (rcon_q[7] ? 8'h1b : 8'h00); // doubling in GF(2^8)
		end
	end

	assign round_key = rk_q;

endmodule

`default_nettype wire

// ==== verilog/aes_cipher.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "aes_params.svh"

module aes_cipher (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  logic [`AES_BLK_S-1:0] plaintext,
	input  logic [`AES_BLK_S-1:0] round_key,
	input  logic [`AES_BLK_S-1:0] round_out,
	output aes_pkg::key_op_e      key_op,
	output logic [`AES_BLK_S-1:0] round_in,
	output logic                  final_round,
	output logic [`AES_BLK_S-1:0] ciphertext,
	output logic                  done
);

	aes_pkg::cipher_state_e state_q;

	logic [`AES_RND_W-1:0] rnd_q;  // round whose result is written at the next edge
	logic [`AES_BLK_S-1:0] pt_q;
	logic [`AES_BLK_S-1:0] blk_q;  // AES state register

	logic accept;
	logic busy;
	logic last_rnd;

	assign accept   = start && (state_q == aes_pkg::ST_IDLE);
	assign busy     = (state_q == aes_pkg::ST_BUSY);
	assign last_rnd = (rnd_q == `AES_RND_W'(`AES_NR));

	// the key expander must see LOAD in the start cycle so that key 0 is ready for whitening
	always_comb begin
		if (accept)
			key_op = aes_pkg::KOP_LOAD;
		else if (busy && !last_rnd)
			key_op = aes_pkg::KOP_NEXT;
		else
			key_op = aes_pkg::KOP_HOLD;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q    <= aes_pkg::ST_IDLE;
			rnd_q      <= '0;
			done       <= 1'b0;
			ciphertext <= '0;
		end else begin
			done <= 1'b0;
			if (accept) begin
				state_q <= aes_pkg::ST_BUSY;
				rnd_q   <= '0;
			end else if (busy) begin
				rnd_q <= rnd_q + 1'b1;
				if (last_rnd) begin
					state_q    <= aes_pkg::ST_IDLE;
					rnd_q      <= '0;
					done       <= 1'b1;
					ciphertext <= round_out; // same value the state register takes
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			pt_q <= plaintext;
		if (busy) begin
			if (rnd_q == '0)
				blk_q <= pt_q ^ round_key; // initial whitening with round key 0
			else
				blk_q <= round_out;
		end
	end

	assign round_in    = blk_q;
	assign final_round = last_rnd; // drops MixColumns in round 10

endmodule

`default_nettype wire

// ==== verilog/aes_core.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "aes_params.svh"

module aes_core (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  logic [`AES_BLK_S-1:0] plaintext,
	input  logic [`AES_KEY_S-1:0] key,
	output logic [`AES_BLK_S-1:0] ciphertext,
	output logic                  done
);

	aes_pkg::key_op_e      key_op;
	logic [`AES_KEY_S-1:0] round_key;
	logic [`AES_BLK_S-1:0] round_in;
	logic [`AES_BLK_S-1:0] round_out;
	logic                  final_round;

	aes_cipher u_cipher (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.plaintext   (plaintext),
		.round_key   (round_key),
		.round_out   (round_out),
		.key_op      (key_op),
		.round_in    (round_in),
		.final_round (final_round),
		.ciphertext  (ciphertext),
		.done        (done)
	);

	aes_round u_round (
		.round_in    (round_in),
		.round_key   (round_key),
		.final_round (final_round),
		.round_out   (round_out)
	);

	aes_key_expand u_key_expand (
		.clk       (clk),
		.reset     (reset),
		.key       (key),
		.key_op    (key_op),
		.round_key (round_key)
	);

endmodule

`default_nettype wire

// ==== tests/aes_core_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "aes_params.svh"

module aes_core_assertions (
	input logic             clk,
	input logic             reset,
	input logic             start,
	input logic             done,
	input aes_pkg::key_op_e key_op
);

	localparam int LATENCY = `AES_NR + 1;

	logic                  load;
	logic [`AES_RND_W-1:0] busy_left; // cycles until the core takes a start again

	assign load = (key_op == aes_pkg::KOP_LOAD);

	always_ff @(posedge clk) begin
		if (reset)
			busy_left <= '0;
		else if (load)
			busy_left <= `AES_RND_W'(LATENCY);
		else if (busy_left != '0)
			busy_left <= busy_left - `AES_RND_W'(1);
	end

	a_done_single: assert property (@(posedge clk) disable iff (reset) !(done && $past(done)))
		else $error("done stayed high for two cycles");

	// done is registered at the eleventh edge after the accept and seen here one edge later
	a_done_latency: assert property (@(posedge clk) disable iff (reset)
		done == $past(load, LATENCY + 1))
		else $error("done does not follow an accepted start by 11 cycles");

	a_load_on_accept: assert property (@(posedge clk) disable iff (reset)
		load |-> (start && busy_left == '0))
		else $error("key expander loaded outside an accepted start");

endmodule

bind aes_core aes_core_assertions u_assertions (
	.clk    (clk),
	.reset  (reset),
	.start  (start),
	.done   (done),
	.key_op (key_op)
);

`default_nettype wire

// ==== tests/aes_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "aes_params.svh"

module aes_core_tb;

	localparam int LATENCY    = `AES_NR + 1; // edges from the accepting edge to done
	localparam int WAIT_LIMIT = 20;

	logic                  clk;
	logic                  reset;
	logic                  start;
	logic [`AES_BLK_S-1:0] plaintext;
	logic [`AES_KEY_S-1:0] key;
	logic [`AES_BLK_S-1:0] ciphertext;
	logic                  done;

	logic [`AES_KEY_S-1:0] vec_key [$];
	logic [`AES_BLK_S-1:0] vec_pt [$];
	logic [`AES_BLK_S-1:0] vec_ct [$];
	int errors;
	int checks;
	int seed;

	aes_core UUT (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.plaintext  (plaintext),
		.key        (key),
		.ciphertext (ciphertext),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic next_cycle(); // inputs change and outputs are read 1 ns after the edge
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [`AES_BLK_S-1:0] exp,
			input logic [`AES_BLK_S-1:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERR %s expected %0h got %0h", name, exp, act);
			errors++;
		end
	endtask

	// a nonzero junk_at pulses start with random data that many cycles into the block
	task automatic run_vector(input int i, input int junk_at);
		int cycles;
		bit seen;
		start = 1'b1;
		plaintext = vec_pt[i];
		key = vec_key[i];
		next_cycle();
		start = 1'b0;
		check_value("done", '0, `AES_BLK_S'(done)); // the previous pulse must be over
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			if (junk_at > 0 && cycles == junk_at) begin
				start = 1'b1;
				plaintext = {$random(seed), $random(seed), $random(seed), $random(seed)};
				key = {$random(seed), $random(seed), $random(seed), $random(seed)};
			end else begin
				start = 1'b0;
			end
			next_cycle();
			cycles++;
			seen = done;
		end
		start = 1'b0;
		if (!seen) begin
			$display("timeout waiting for done");
			errors++;
		end else begin
			checks++;
			assert (cycles == LATENCY) else begin
				$display("done came %0d cycles after the start instead of %0d", cycles, LATENCY);
				errors++;
			end
			check_value("ciphertext", vec_ct[i], ciphertext);
		end
	endtask

	// idle cycles after a block, the result has to stay put
	task automatic check_hold(input int i, input int n);
		repeat (n) begin
			next_cycle();
			check_value("done", '0, `AES_BLK_S'(done));
			check_value("ciphertext", vec_ct[i], ciphertext);
		end
	endtask

	initial begin
		int fd;
		int n;
		logic [`AES_KEY_S-1:0] k;
		logic [`AES_BLK_S-1:0] p;
		logic [`AES_BLK_S-1:0] c;
		errors = 0;
		checks = 0;
		seed = 41;
		reset = 1'b1;
		start = 1'b0;
		plaintext = '0;
		key = '0;

		fd = $fopen("tests/aes_core_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file tests/aes_core_stim.txt");
			errors++;
		end else begin
			n = $fscanf(fd, "%h %h %h\n", k, p, c); // key, plaintext, expected ciphertext
			while (n == 3) begin
				vec_key.push_back(k);
				vec_pt.push_back(p);
				vec_ct.push_back(c);
				n = $fscanf(fd, "%h %h %h\n", k, p, c);
			end
			$fclose(fd);
			if (vec_key.size() == 0) begin
				$display("the vector file holds no usable vectors");
				errors++;
			end
		end

		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		repeat (3) begin
			next_cycle();
			check_value("done", '0, `AES_BLK_S'(done));
			check_value("ciphertext", '0, ciphertext);
		end

		if (vec_key.size() > 0) begin
			for (int i = 0; i < vec_key.size(); i++) begin
				run_vector(i, 0);
				check_hold(i, 2);
			end
			run_vector(0, 4); // second start lands while the block is busy
			check_hold(0, 2);
			for (int i = 0; i < vec_key.size(); i++)
				run_vector(i, 0); // each start goes out in the done cycle
			check_hold(vec_key.size() - 1, 5);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/aes_core_stim.txt ====
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 a1f6258c877d5fcd8964484538bfc92c
00000000000000000000000000000000 ffffffffffffffffffffffffffffffff 3f5b8cc9ea855a0afa7347d23e8d664e
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
00000000000000000000000000000000 9798c4640bad75c7c3227db910174e72 a9a1631bf4996954ebc093957b234589
10a58869d74be5a374cf867cfb473859 00000000000000000000000000000000 6d251e6944b051e04eaa6fb4dbf78465

// ==== build.f ====
+incdir+verilog
verilog/aes_pkg.sv
verilog/aes_sbox.sv
verilog/aes_round.sv
verilog/aes_key_expand.sv
verilog/aes_cipher.sv
verilog/aes_core.sv
tests/aes_core_assertions.sv
tests/aes_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module aes_core_tb -f build.f -o sim_aes

./obj_dir/sim_aes > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Errors found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"
